// File: bench/loader_patterns.mem
// Columns: iNES header bytes 0 to 15, invert_mirroring, expected error, expected mapper flags
// All values hex, one test case per line
// Clean iNES 1.0, mapper 41, one PRG page and one CHR page
4E 45 53 1A 01 01 13 40 00 00 00 00 00 00 00 00 0 0 02004041
4E 45 53 1A 01 01 13 40 00 00 00 00 00 00 00 00 1 0 02000041
// Clean iNES 1.0 with no CHR pages
4E 45 53 1A 01 00 00 00 00 00 00 00 00 00 00 00 0 0 00008000
// Dirty 1.0 header, byte 12 set so the mapper high nibble drops
4E 45 53 1A 01 00 48 20 00 00 00 00 55 00 00 00 0 0 00018004
4E 45 53 1A 01 00 48 20 00 00 00 00 55 00 00 00 1 0 0001C004
// NES 2.0 with submapper byte, PRG-RAM shift and piano console code
4E 45 53 1A 01 01 A1 18 35 00 07 00 00 00 00 19 0 0 5C6A401A
4E 45 53 1A 01 01 A1 18 35 00 07 00 00 00 00 19 1 0 5C6A001A
// Bad magic
4E 45 53 00 01 01 13 40 00 00 00 00 00 00 00 00 0 1 02004041
// Trainer present
4E 45 53 1A 01 01 17 40 00 00 00 00 00 00 00 00 1 1 02000041

// File: bench/nes_loader_checker.sv
// NES loader protocol checker
// Host handshake, memory slot and status assertions

`timescale 1ns/1ps

module nes_loader_checker (
	input logic                           clk,
	input logic                           reset_nes,
	input nes_loader_pkg::host_byte_t     host_byte,
	input logic                           host_wait,
	input logic                           mem_slot,
	input nes_loader_pkg::mem_write_t     mem_wr,
	input nes_loader_pkg::loader_status_t status
);

	// Writes only go out on a memory slot
	slot_write: assert property (@(posedge clk) disable iff (reset_nes)
		mem_wr.we |-> mem_slot)
		else $error("memory write issued outside a memory slot");

	no_byte_in_wait: assert property (@(posedge clk) disable iff (reset_nes)
		host_byte.valid |-> !host_wait)
		else $error("host byte sent while host_wait was high");

	done_not_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(status.done && status.busy))
		else $error("done and busy high together");

	error_done: assert property (@(posedge clk) disable iff (reset_nes)
		status.error |-> status.done)
		else $error("error high without done");

endmodule

bind nes_loader_top nes_loader_checker chk_i (
	.clk       (clk),
	.reset_nes (reset_nes),
	.host_byte (host_byte),
	.host_wait (host_wait),
	.mem_slot  (mem_slot),
	.mem_wr    (mem_wr),
	.status    (status)
);

// File: bench/nes_loader_tb.sv
// NES cartridge loader testbench
// Replays header patterns, streams random ROM bytes through the
// host handshake and scoreboards every memory write

`timescale 1ns/1ps
`include "nes_loader_config.svh"

module nes_loader_tb;
	import nes_loader_pkg::*;

	localparam int FIELDS    = 19;          // Header bytes, invert, error, flags
	localparam int MAX_CASES = 16;
	localparam int TRAILING  = 4;           // Bytes sent after the load ends

	logic           clk;
	logic           reset_nes;
	logic           download;
	host_byte_t     host_byte;
	logic           invert_mirroring;
	logic           mem_slot;
	logic           host_wait;
	mem_write_t     mem_wr;
	mapper_flags_t  mapper_flags;
	loader_status_t status;

	logic [31:0] pat_mem [0:MAX_CASES*FIELDS-1];
	logic [29:0] exp_q [$];                 // {addr, data} per expected write
	logic [29:0] exp_entry;
	logic [31:0] rnd;
	int          write_count;
	int          num_cases;
	int          total_bytes;
	int          watch_limit;
	int          slot_cnt;

	nes_loader_top dut_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.host_byte        (host_byte),
		.invert_mirroring (invert_mirroring),
		.mem_slot         (mem_slot),
		.host_wait        (host_wait),
		.mem_wr           (mem_wr),
		.mapper_flags     (mapper_flags),
		.status           (status)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// One memory slot every LDR_SLOT_PERIOD clocks
	always @(posedge clk) begin
		#2;
		slot_cnt = (slot_cnt + 1) % `LDR_SLOT_PERIOD;
		mem_slot = (slot_cnt == 0);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	// Holds off while a write is pending, then one valid cycle
	task automatic send_byte(input logic [7:0] b);
		while (host_wait)
			next_cycle();
		host_byte = '{valid: 1'b1, data: b};
		next_cycle();
		host_byte.valid = 1'b0;
	endtask

	//////////////////////////////
	// Write scoreboard
	//////////////////////////////
	always @(negedge clk) begin
		if (!reset_nes && mem_wr.we) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected memory write at %0t ns to address %h", $time, mem_wr.addr);
				$display("TEST FAILED");
				$fatal(1);
			end else begin
				exp_entry = exp_q.pop_front();
				check_value(32'(mem_wr.addr), 32'(exp_entry[29:8]), "write address");
				check_value(32'(mem_wr.data), 32'(exp_entry[7:0]), "write data");
				write_count++;
			end
		end
	end

	task automatic run_case(input int c);
		logic [7:0]  hdr [0:`LDR_HDR_BYTES-1];
		logic        exp_err;
		logic [31:0] exp_flags;
		int          prg_n;
		int          chr_n;
		int          exp_writes;
		for (int i = 0; i < `LDR_HDR_BYTES; i++)
			hdr[i] = pat_mem[c*FIELDS + i][7:0];
		exp_err    = pat_mem[c*FIELDS + 17][0];
		exp_flags  = pat_mem[c*FIELDS + 18];
		prg_n      = int'(hdr[4]) << `LDR_PRG_PAGE_LOG2;
		chr_n      = int'(hdr[5]) << `LDR_CHR_PAGE_LOG2;
		exp_writes = exp_err ? 0 : prg_n + chr_n;
		write_count      = 0;
		invert_mirroring = pat_mem[c*FIELDS + 16][0];
		download         = 1'b1;
		next_cycle();                       // Download edge seen, header capture starts
		for (int i = 0; i < `LDR_HDR_BYTES; i++)
			send_byte(hdr[i]);
		while (!(status.busy || status.done))
			next_cycle();
		next_cycle();                       // CHECK
		for (int i = 0; i < exp_writes; i++) begin
			rnd = xorshift32(rnd);
			if (i < prg_n)
				exp_q.push_back({`LDR_PRG_BASE + 22'(i), rnd[7:0]});
			else
				exp_q.push_back({`LDR_CHR_BASE + 22'(i - prg_n), rnd[7:0]});
			send_byte(rnd[7:0]);
		end
		while (!status.done || host_wait)
			next_cycle();
		next_cycle();                       // Flags latch behind done
		check_value(32'(status.busy), 0, $sformatf("case %0d busy", c));
		check_value(32'(status.error), 32'(exp_err), $sformatf("case %0d error", c));
		check_value(32'(status.rom_loaded), 1, $sformatf("case %0d rom_loaded", c));
		check_value(mapper_flags, exp_flags, $sformatf("case %0d mapper flags", c));
		check_value(write_count, exp_writes, $sformatf("case %0d write count", c));
		for (int i = 0; i < TRAILING; i++) begin
			rnd = xorshift32(rnd);
			send_byte(rnd[7:0]);
		end
		repeat (2 * `LDR_SLOT_PERIOD)
			next_cycle();
		check_value(32'(status.done), 1, $sformatf("case %0d done after trailing", c));
		check_value(32'(status.error), 32'(exp_err),
			$sformatf("case %0d error after trailing", c));
		download = 1'b0;
		next_cycle();
	endtask

	initial begin
		reset_nes        = 1'b1;
		download         = 1'b0;
		host_byte        = '0;
		invert_mirroring = 1'b0;
		mem_slot         = 1'b0;
		slot_cnt         = 0;
		rnd              = 32'd11;
		write_count      = 0;
		num_cases        = 0;
		total_bytes      = 0;
		watch_limit      = 0;
		for (int i = 0; i < MAX_CASES*FIELDS; i++)
			pat_mem[i] = {16'hFFFF, 16'(i)};        // Above any header byte
		$readmemh("bench/loader_patterns.mem", pat_mem);
		while (num_cases < MAX_CASES && pat_mem[num_cases*FIELDS] <= 32'hFF)
			num_cases++;
		for (int c = 0; c < num_cases; c++) begin
			total_bytes += `LDR_HDR_BYTES + TRAILING;
			if (!pat_mem[c*FIELDS + 17][0])
				total_bytes += (int'(pat_mem[c*FIELDS + 4][7:0]) << `LDR_PRG_PAGE_LOG2) +
					(int'(pat_mem[c*FIELDS + 5][7:0]) << `LDR_CHR_PAGE_LOG2);
		end
		watch_limit = total_bytes * 12 + 1000;
		if (num_cases == 0) begin
			$display("No test cases found in bench/loader_patterns.mem");
			$display("TEST FAILED");
			$fatal(1);
		end
		repeat (2) @(posedge clk);
		#2 reset_nes = 1'b0;
		for (int c = 0; c < num_cases; c++)
			run_case(c);
		$display("TEST OK");
		$finish;
	end

	// Watchdog
	initial begin
		wait (watch_limit != 0);
		repeat (watch_limit) @(posedge clk);
		$display("Simulation timed out after %0d cycles without finishing the loads", watch_limit);
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

// File: nes_loader_top.f
+incdir+rtl
rtl/nes_loader_pkg.sv
rtl/ines_header_decode.sv
rtl/game_loader_fsm.sv
rtl/mem_write_buffer.sv
rtl/nes_loader_top.sv
bench/nes_loader_checker.sv
bench/nes_loader_tb.sv

// File: rtl/game_loader_fsm.sv
// Cartridge load sequencer
// Captures the 16-byte iNES header, then streams PRG and CHR
// bytes to memory and reports load status

`timescale 1ns/1ps
`include "nes_loader_config.svh"

module game_loader_fsm (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           download,
	input  nes_loader_pkg::host_byte_t     host_byte,
	input  logic                           hdr_ok,
	input  logic [`LDR_ADDR_W-1:0]         prg_bytes,
	input  logic [`LDR_ADDR_W-1:0]         chr_bytes,
	output nes_loader_pkg::ines_header_u   header,
	output nes_loader_pkg::mem_write_t     wr_req,
	output nes_loader_pkg::loader_status_t status
);
	import nes_loader_pkg::*;

	localparam int ADDR_W    = `LDR_ADDR_W;
	localparam int HDR_CNT_W = $clog2(`LDR_HDR_BYTES);
	localparam int HDR_W     = 8 * `LDR_HDR_BYTES;

	loader_state_e          state;
	logic                   download_q;
	logic [HDR_CNT_W-1:0]   hdr_cnt;
	logic [ADDR_W-1:0]      remaining;      // Bytes left in current segment
	logic [ADDR_W-1:0]      addr;
	logic                   wr_we;
	logic [ADDR_W-1:0]      wr_addr;
	logic [7:0]             wr_data;
	logic                   start;
	logic                   hdr_take;
	logic                   data_take;
	logic                   seg_end;

	assign start     = download & ~download_q;
	assign hdr_take  = host_byte.valid & ~start & (state == HEADER);
	assign data_take = host_byte.valid & ~start & (remaining != '0) &
		((state == PRG) || (state == CHR));
	// Last byte taken, or an empty segment
	assign seg_end   = (data_take && remaining == ADDR_W'(1)) || (remaining == '0);

	assign wr_req = '{we: wr_we, addr: wr_addr, data: wr_data};

	//////////////////////////////
	// Sequencer
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= DONE;         // Idle until a download starts
			download_q <= 1'b0;
			hdr_cnt    <= '0;
			remaining  <= '0;
			addr       <= '0;
			wr_we      <= 1'b0;
			status     <= '0;
		end else begin
			download_q <= download;
			wr_we      <= data_take;

			if (download && host_byte.valid)
				status.rom_loaded <= 1'b1;

			if (start) begin
				state        <= HEADER;
				hdr_cnt      <= '0;
				status.busy  <= 1'b0;
				status.done  <= 1'b0;
				status.error <= 1'b0;
			end else begin
				case (state)
				HEADER: begin
					if (hdr_take) begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt == HDR_CNT_W'(`LDR_HDR_BYTES - 1)) begin
							state       <= CHECK;
							status.busy <= 1'b1;
						end
					end
				end
				CHECK: begin
					if (hdr_ok) begin
						state     <= PRG;
						addr      <= `LDR_PRG_BASE;
						remaining <= prg_bytes;
					end else begin
						state <= ERROR;
					end
				end
				PRG, CHR: begin
					if (data_take) begin
						addr      <= addr + 1'b1;
						remaining <= remaining - 1'b1;
					end
					if (seg_end) begin
						if (state == PRG && chr_bytes != '0) begin
							state     <= CHR;
							addr      <= `LDR_CHR_BASE;
							remaining <= chr_bytes;
						end else begin
							state       <= DONE;
							status.done <= 1'b1;
							status.busy <= 1'b0;
						end
					end
				end
				ERROR: begin
					status.done  <= 1'b1;
					status.error <= 1'b1;
					status.busy  <= 1'b0;
				end
				default: ;                  // DONE ignores trailing bytes
				endcase
			end
		end
	end

	// Header shift register and write payload
	always_ff @(posedge clk) begin
		if (hdr_take)
			header <= {header[HDR_W-9:0], host_byte.data};  // Byte 0 ends up on top
		if (data_take) begin
			wr_addr <= addr;
			wr_data <= host_byte.data;
		end
	end

endmodule

// File: rtl/ines_header_decode.sv
// iNES header decoder
// Checks the captured header, sizes the ROM segments and
// builds the mapper flags word

`timescale 1ns/1ps
`include "nes_loader_config.svh"

module ines_header_decode (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  nes_loader_pkg::ines_header_u  header,
	input  logic                          invert_mirroring,
	input  logic                          load_done,
	output logic                          hdr_ok,
	output logic [`LDR_ADDR_W-1:0]        prg_bytes,
	output logic [`LDR_ADDR_W-1:0]        chr_bytes,
	output nes_loader_pkg::mapper_flags_t mapper_flags
);
	import nes_loader_pkg::*;

	localparam int ADDR_W = `LDR_ADDR_W;

	logic          is_nes2;
	logic          is_dirty;
	logic          load_done_q;
	mapper_flags_t flags_c;

	// Smallest k with pages <= 2^k, capped at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--)
			if ({1'b0, pages} <= (9'd1 << k))
				code = 3'(k);
		return code;
	endfunction

	// Trainers are not supported
	assign hdr_ok = (header.ines1.magic == `LDR_MAGIC) && !header.ines1.flags6[2];

	assign is_nes2  = (header.ines1.flags7[3:2] == 2'b10);
	// Junk in the tail bytes of an old 1.0 dump
	assign is_dirty = !is_nes2 &&
		((|header.ines1.pad[9][7:1]) || (|header.ines1.pad[10:15]));

	assign prg_bytes = ADDR_W'(header.ines1.prg_pages) << `LDR_PRG_PAGE_LOG2;
	assign chr_bytes = ADDR_W'(header.ines1.chr_pages) << `LDR_CHR_PAGE_LOG2;

	always_comb begin
		flags_c             = '0;
		flags_c.mapper      = {is_dirty ? 4'h0 : header.ines1.flags7[7:4],
			header.ines1.flags6[7:4]};
		flags_c.prg_size    = size_code(header.ines1.prg_pages);
		flags_c.chr_size    = size_code(header.ines1.chr_pages);
		flags_c.mirroring   = header.ines1.flags6[0] ^ invert_mirroring;
		flags_c.chr_ram     = (header.ines1.chr_pages == 8'd0);
		flags_c.four_screen = header.ines1.flags6[3];
		flags_c.has_saves   = header.ines1.flags6[1];
		// NES 2.0 only fields
		if (is_nes2) begin
			flags_c.nes2_mapper = header.nes2.mapper_sub;
			flags_c.prg_ram     = header.nes2.prg_ram_shift[3:0];
			flags_c.piano       = (header.nes2.console_type[5:0] == 6'h19);
		end
	end

	// Held for the console once the load completes
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			load_done_q  <= 1'b0;
			mapper_flags <= '0;
		end else begin
			load_done_q <= load_done;
			if (load_done && !load_done_q)
				mapper_flags <= flags_c;    // Rising edge of done only
		end
	end

endmodule

// File: rtl/mem_write_buffer.sv
// Single-entry memory write buffer
// Holds one write until the next memory slot and stalls the host

`timescale 1ns/1ps
`include "nes_loader_config.svh"

module mem_write_buffer (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  nes_loader_pkg::mem_write_t wr_req,
	input  logic                       mem_slot,
	output nes_loader_pkg::mem_write_t mem_wr,
	output logic                       host_wait
);
	import nes_loader_pkg::*;

	logic                   pending;
	logic                   commit;
	logic [`LDR_ADDR_W-1:0] held_addr;
	logic [7:0]             held_data;

	assign commit = pending & mem_slot;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending <= 1'b0;
		end else begin
			if (commit)
				pending <= 1'b0;
			if (wr_req.we)
				pending <= 1'b1;        // New request wins
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req.we) begin
			held_addr <= wr_req.addr;
			held_data <= wr_req.data;
		end
	end

	assign mem_wr = '{we: commit, addr: held_addr, data: held_data};

	// Covers the request cycle too so a byte never lands on a full buffer
	assign host_wait = pending | wr_req.we;

endmodule

// File: rtl/nes_loader_config.svh
// NES cartridge loader configuration
// Memory map, iNES page sizes and header magic

`ifndef NES_LOADER_CONFIG_SVH
`define NES_LOADER_CONFIG_SVH

////////////////////////////////
// Memory map
////////////////////////////////
`define LDR_ADDR_W          22
`define LDR_PRG_BASE        22'h000000
`define LDR_CHR_BASE        22'h200000

// Page sizes as log2 of bytes
`define LDR_PRG_PAGE_LOG2   14      // 16 KB PRG pages
`define LDR_CHR_PAGE_LOG2   13      // 8 KB CHR pages

////////////////////////////////
// iNES header
////////////////////////////////
`define LDR_HDR_BYTES       16
`define LDR_MAGIC           32'h4E45_531A   // "NES" then EOF

// One memory slot every this many clocks by default
`define LDR_SLOT_PERIOD     4

`endif

// File: rtl/nes_loader_pkg.sv
// NES loader shared types
// Header views, mapper flags, status and byte/write transfer words

`include "nes_loader_config.svh"

package nes_loader_pkg;

	////////////////////////////////
	// Header views
	////////////////////////////////

	// Plain iNES 1.0 layout
	typedef struct packed {
		logic [31:0]      magic;
		logic [7:0]       prg_pages;
		logic [7:0]       chr_pages;
		logic [7:0]       flags6;
		logic [7:0]       flags7;
		logic [8:15][7:0] pad;          // Bytes 8 to 15
	} ines1_hdr_t;

	// NES 2.0 layout of the same 16 bytes
	typedef struct packed {
		logic [31:0] magic;
		logic [7:0]  prg_pages;
		logic [7:0]  chr_pages;
		logic [7:0]  flags6;
		logic [7:0]  flags7;
		logic [7:0]  mapper_sub;        // Mapper high nibble and submapper
		logic [7:0]  rom_size_msb;
		logic [7:0]  prg_ram_shift;
		logic [31:0] reserved;          // Bytes 11 to 14
		logic [7:0]  console_type;
	} nes2_hdr_t;

	typedef union packed {
		ines1_hdr_t ines1;
		nes2_hdr_t  nes2;
	} ines_header_u;

	////////////////////////////////
	// Flags, status and transfers
	////////////////////////////////

	typedef struct packed {
		logic       spare;
		logic       piano;
		logic [3:0] prg_ram;
		logic       has_saves;
		logic [7:0] nes2_mapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;             // Bits 7:0
	} mapper_flags_t;

	typedef struct packed {
		logic busy;
		logic done;
		logic error;
		logic rom_loaded;
	} loader_status_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} host_byte_t;

	typedef struct packed {
		logic                   we;
		logic [`LDR_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} mem_write_t;

	typedef enum logic [2:0] {HEADER, CHECK, PRG, CHR, DONE, ERROR} loader_state_e;

endpackage

// File: rtl/nes_loader_top.sv
// NES cartridge loader top level
// Sequencer, header decoder and memory write buffer

`timescale 1ns/1ps
`include "nes_loader_config.svh"

module nes_loader_top (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           download,
	input  nes_loader_pkg::host_byte_t     host_byte,
	input  logic                           invert_mirroring,
	input  logic                           mem_slot,
	output logic                           host_wait,
	output nes_loader_pkg::mem_write_t     mem_wr,
	output nes_loader_pkg::mapper_flags_t  mapper_flags,
	output nes_loader_pkg::loader_status_t status
);
	import nes_loader_pkg::*;

	ines_header_u           header;
	mem_write_t             wr_req;
	logic                   hdr_ok;
	logic [`LDR_ADDR_W-1:0] prg_bytes;
	logic [`LDR_ADDR_W-1:0] chr_bytes;

	game_loader_fsm fsm_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.download  (download),
		.host_byte (host_byte),
		.hdr_ok    (hdr_ok),
		.prg_bytes (prg_bytes),
		.chr_bytes (chr_bytes),
		.header    (header),
		.wr_req    (wr_req),
		.status    (status)
	);

	ines_header_decode decode_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.load_done        (status.done),        // Flags latch at end of load
		.hdr_ok           (hdr_ok),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.mapper_flags     (mapper_flags)
	);

	mem_write_buffer wbuf_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wr_req    (wr_req),
		.mem_slot  (mem_slot),
		.mem_wr    (mem_wr),
		.host_wait (host_wait)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the loader testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module nes_loader_tb \
	-f nes_loader_top.f -o nes_loader_sim &&
./obj_dir/nes_loader_sim ||
{ echo "simulation failed"; exit 1; }
